/* hdl/soc_data_pkg.sv */
package soc_data_pkg;

    // data width of the bus
    parameter int XLEN = 32;

    // byte lanes per word
    parameter int LANES = 4;

    // one bus word, seen whole or lane by lane
    typedef union packed {
        logic [XLEN-1:0]         word;
        logic [LANES-1:0][7:0]   bytes;
    } bus_word_u;

endpackage

/* hdl/soc_map_pkg.sv */
package soc_map_pkg;

    // target picked by address bits 31:24
    typedef enum logic [2:0] {
        REG_NONE  = 3'd0,
        REG_CLINT = 3'd1,
        REG_MEM   = 3'd2,
        REG_BTN   = 3'd3,
        REG_CNT   = 3'd4
    } region_e;

    // region byte of each target
    localparam logic [7:0] REGION_CLINT_BASE = 8'h02;
    localparam logic [7:0] REGION_MEM_BASE   = 8'h10;
    localparam logic [7:0] REGION_BTN_BASE   = 8'h20;
    localparam logic [7:0] REGION_CNT_BASE   = 8'h30;

    // clint register offsets, usual riscv layout
    localparam logic [15:0] CLINT_MSIP_OFF    = 16'h0000;
    localparam logic [15:0] CLINT_CMP_LO_OFF  = 16'h4000;
    localparam logic [15:0] CLINT_CMP_HI_OFF  = 16'h4004;
    localparam logic [15:0] CLINT_TIME_LO_OFF = 16'hBFF8;
    localparam logic [15:0] CLINT_TIME_HI_OFF = 16'hBFFC;

    // counter block offsets
    localparam logic [3:0] CNT_CYCLE_OFF = 4'h0;
    localparam logic [3:0] CNT_TICK_OFF  = 4'h4;

endpackage

/* hdl/cpu_bus_if.sv */
`timescale 1ns/1ps

// one decoded access, decoder to a single target
interface cpu_bus_if
    import soc_data_pkg::*;
();

    // strobes already gated by region
    logic             sel_ren;
    logic             sel_wen;
    // address with the region byte stripped
    logic [23:0]      offset;
    bus_word_u        wdata;
    logic [LANES-1:0] byte_select;
    // read word, valid the cycle after sel_ren
    bus_word_u        rdata;

    modport decoder (
        output sel_ren, sel_wen, offset, wdata, byte_select,
        input  rdata
    );

    modport target (
        input  sel_ren, sel_wen, offset, wdata, byte_select,
        output rdata
    );

endinterface

/* hdl/reset_sync.sv */
`timescale 1ns/1ps

module reset_sync #(
    parameter int RESET_CYCLES_LOG2 = 4
) (
    input  logic clk,
    input  logic ext_reset,
    output logic resetn
);

    logic [RESET_CYCLES_LOG2-1:0] reset_cnt;

    // clears at once on ext_reset low, counts up after release
    always_ff @(posedge clk or negedge ext_reset) begin
        if (!ext_reset) begin
            reset_cnt <= '0;
        end else if (!resetn) begin
            reset_cnt <= reset_cnt + 1'b1;
        end
    end

    // saturates at all ones, which also stops the count
    assign resetn = &reset_cnt;

endmodule

/* hdl/bus_decoder.sv */
`timescale 1ns/1ps

module bus_decoder
    import soc_data_pkg::*;
    import soc_map_pkg::*;
#(
    parameter int MEM_WORDS = 256
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [31:0]      bus_addr,
    input  logic [XLEN-1:0]  bus_wdata,
    input  logic [LANES-1:0] bus_byte_select,
    input  logic             bus_ren,
    input  logic             bus_wen,
    output bus_word_u        bus_rdata,
    output logic             bus_ready,
    output logic             bus_error,
    cpu_bus_if.decoder       mem_bus,
    cpu_bus_if.decoder       clint_bus,
    cpu_bus_if.decoder       btn_bus,
    cpu_bus_if.decoder       cnt_bus
);

    // index bits the memory depth needs
    localparam int MEM_AW = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    region_e   region;
    region_e   region_q;
    logic      rd_q;
    bus_word_u wdata_u;

    // region from the top address byte
    always_comb begin
        case (bus_addr[31:24])
            REGION_CLINT_BASE: region = REG_CLINT;
            REGION_MEM_BASE:   region = REG_MEM;
            REGION_BTN_BASE:   region = REG_BTN;
            REGION_CNT_BASE:   region = REG_CNT;
            default:           region = REG_NONE;
        endcase
    end

    assign wdata_u = bus_wdata;

    // only one target ever sees a strobe
    assign mem_bus.sel_ren   = bus_ren && (region == REG_MEM);
    assign mem_bus.sel_wen   = bus_wen && (region == REG_MEM);
    assign clint_bus.sel_ren = bus_ren && (region == REG_CLINT);
    assign clint_bus.sel_wen = bus_wen && (region == REG_CLINT);
    assign btn_bus.sel_ren   = bus_ren && (region == REG_BTN);
    assign btn_bus.sel_wen   = bus_wen && (region == REG_BTN);
    assign cnt_bus.sel_ren   = bus_ren && (region == REG_CNT);
    assign cnt_bus.sel_wen   = bus_wen && (region == REG_CNT);

    // memory gets a word index, the rest the byte offset
    assign mem_bus.offset   = {{(24 - MEM_AW){1'b0}}, bus_addr[MEM_AW+1:2]};
    assign clint_bus.offset = bus_addr[23:0];
    assign btn_bus.offset   = bus_addr[23:0];
    assign cnt_bus.offset   = bus_addr[23:0];

    assign mem_bus.wdata   = wdata_u;
    assign clint_bus.wdata = wdata_u;
    assign btn_bus.wdata   = wdata_u;
    assign cnt_bus.wdata   = wdata_u;

    assign mem_bus.byte_select   = bus_byte_select;
    assign clint_bus.byte_select = bus_byte_select;
    assign btn_bus.byte_select   = bus_byte_select;
    assign cnt_bus.byte_select   = bus_byte_select;

    // remember what is in flight for the response cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            region_q  <= REG_NONE;
            rd_q      <= 1'b0;
            bus_ready <= 1'b0;
            bus_error <= 1'b0;
        end else begin
            region_q  <= region;
            rd_q      <= bus_ren;
            bus_ready <= bus_ren || bus_wen;
            bus_error <= (bus_ren || bus_wen) && (region == REG_NONE);
        end
    end

    // targets hold registered data, just pick one
    always_comb begin
        bus_rdata = '0;
        if (rd_q) begin
            case (region_q)
                REG_MEM:   bus_rdata = mem_bus.rdata;
                REG_CLINT: bus_rdata = clint_bus.rdata;
                REG_BTN:   bus_rdata = btn_bus.rdata;
                REG_CNT:   bus_rdata = cnt_bus.rdata;
                default:   bus_rdata = '0;
            endcase
        end
    end

endmodule

/* hdl/data_memory.sv */
`timescale 1ns/1ps

module data_memory
    import soc_data_pkg::*;
#(
    parameter int MEM_WORDS = 256
) (
    input logic       clk,
    cpu_bus_if.target bus
);

    localparam int MEM_AW = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    // word array, each word seen through its byte lanes
    bus_word_u mem [MEM_WORDS];

    logic [MEM_AW-1:0] idx;

    // decoder already reduced the offset to a word index
    assign idx = bus.offset[MEM_AW-1:0];

    // byte lane merge on write
    always_ff @(posedge clk) begin
        if (bus.sel_wen) begin
            for (int i = 0; i < LANES; i++) begin
                if (bus.byte_select[i]) begin
                    mem[idx].bytes[i] <= bus.wdata.bytes[i];
                end
            end
        end
    end

    // registered read, held until the next read
    always_ff @(posedge clk) begin
        if (bus.sel_ren) begin
            bus.rdata <= mem[idx];
        end
    end

endmodule

/* hdl/clint.sv */
`timescale 1ns/1ps

module clint
    import soc_data_pkg::*;
    import soc_map_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      mtime_tick,
    cpu_bus_if.target bus,
    output logic      msw_irq,
    output logic      mtimer_irq
);

    logic        msip;
    logic [63:0] mtime;
    logic [63:0] mtimecmp;
    // timer irq stays quiet until software sets a compare value
    logic        cmp_armed;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            msip       <= 1'b0;
            mtime      <= '0;
            mtimecmp   <= '0;
            cmp_armed  <= 1'b0;
            mtimer_irq <= 1'b0;
        end else begin
            if (mtime_tick) begin
                mtime <= mtime + 64'd1;
            end
            // compare registered, irq lags mtime by one cycle
            mtimer_irq <= cmp_armed && (mtime >= mtimecmp);
            if (bus.sel_wen) begin
                // msip is bit 0 of lane 0
                if (bus.offset == {8'h00, CLINT_MSIP_OFF} && bus.byte_select[0]) begin
                    msip <= bus.wdata.word[0];
                end
                // mtimecmp written as two words, lane by lane
                if (bus.offset == {8'h00, CLINT_CMP_LO_OFF}) begin
                    cmp_armed <= 1'b1;
                    for (int i = 0; i < LANES; i++) begin
                        if (bus.byte_select[i]) begin
                            mtimecmp[8*i +: 8] <= bus.wdata.bytes[i];
                        end
                    end
                end
                if (bus.offset == {8'h00, CLINT_CMP_HI_OFF}) begin
                    cmp_armed <= 1'b1;
                    for (int i = 0; i < LANES; i++) begin
                        if (bus.byte_select[i]) begin
                            mtimecmp[32 + 8*i +: 8] <= bus.wdata.bytes[i];
                        end
                    end
                end
            end
        end
    end

    assign msw_irq = msip;

    // read port, unknown offsets give zero
    always_ff @(posedge clk) begin
        if (bus.sel_ren) begin
            case (bus.offset)
                {8'h00, CLINT_MSIP_OFF}:    bus.rdata.word <= {31'd0, msip};
                {8'h00, CLINT_CMP_LO_OFF}:  bus.rdata.word <= mtimecmp[31:0];
                {8'h00, CLINT_CMP_HI_OFF}:  bus.rdata.word <= mtimecmp[63:32];
                {8'h00, CLINT_TIME_LO_OFF}: bus.rdata.word <= mtime[31:0];
                {8'h00, CLINT_TIME_HI_OFF}: bus.rdata.word <= mtime[63:32];
                default:                    bus.rdata.word <= '0;
            endcase
        end
    end

endmodule

/* hdl/button_port.sv */
`timescale 1ns/1ps

module button_port (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [7:0] buttons,
    cpu_bus_if.target  bus
);

    // two flop sync, pins are asynchronous to clk
    logic [7:0] btn_meta;
    logic [7:0] btn_sync;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            btn_meta <= '0;
            btn_sync <= '0;
        end else begin
            btn_meta <= buttons;
            btn_sync <= btn_meta;
        end
    end

    // pattern in lane 0, upper lanes zero
    always_ff @(posedge clk) begin
        if (bus.sel_ren) begin
            bus.rdata.word     <= '0;
            bus.rdata.bytes[0] <= btn_sync;
        end
    end

endmodule

/* hdl/tick_counter.sv */
`timescale 1ns/1ps

module tick_counter #(
    parameter int DIVISION = 50
) (
    input  logic        clk,
    input  logic        rst_n,
    output logic [31:0] count,
    output logic        tick
);

    // prescaler needs at least one bit, even for DIVISION 1
    localparam int PW = (DIVISION > 1) ? $clog2(DIVISION) : 1;

    logic [PW-1:0] presc;

    // last prescaler state marks the tick
    assign tick = (presc == PW'(DIVISION - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            presc <= '0;
            count <= '0;
        end else if (tick) begin
            presc <= '0;
            count <= count + 32'd1;
        end else begin
            presc <= presc + 1'b1;
        end
    end

endmodule

/* hdl/soc_periph_top.sv */
`timescale 1ns/1ps

module soc_periph_top
    import soc_data_pkg::*;
    import soc_map_pkg::*;
#(
    parameter int MEM_WORDS         = 256,
    parameter int MTIME_DIVISION    = 50,
    parameter int RESET_CYCLES_LOG2 = 4
) (
    input  logic             clk,
    input  logic             ext_reset,
    input  logic [31:0]      bus_addr,
    input  logic [XLEN-1:0]  bus_wdata,
    input  logic [LANES-1:0] bus_byte_select,
    input  logic             bus_ren,
    input  logic             bus_wen,
    output logic [XLEN-1:0]  bus_rdata,
    output logic             bus_ready,
    output logic             bus_error,
    input  logic [7:0]       buttons,
    output logic             msw_irq,
    output logic             mtimer_irq,
    output logic             sys_resetn
);

    logic [31:0] cycle_count;
    logic [31:0] tick_count;
    logic        mtime_tick;

    cpu_bus_if mem_bus ();
    cpu_bus_if clint_bus ();
    cpu_bus_if btn_bus ();
    cpu_bus_if cnt_bus ();

    // design reset, also handed back to the master
    reset_sync #(.RESET_CYCLES_LOG2(RESET_CYCLES_LOG2)) u_reset_sync (
        .clk       (clk),
        .ext_reset (ext_reset),
        .resetn    (sys_resetn)
    );

    bus_decoder #(.MEM_WORDS(MEM_WORDS)) u_bus_decoder (
        .clk             (clk),
        .rst_n           (sys_resetn),
        .bus_addr        (bus_addr),
        .bus_wdata       (bus_wdata),
        .bus_byte_select (bus_byte_select),
        .bus_ren         (bus_ren),
        .bus_wen         (bus_wen),
        .bus_rdata       (bus_rdata),
        .bus_ready       (bus_ready),
        .bus_error       (bus_error),
        .mem_bus         (mem_bus.decoder),
        .clint_bus       (clint_bus.decoder),
        .btn_bus         (btn_bus.decoder),
        .cnt_bus         (cnt_bus.decoder)
    );

    data_memory #(.MEM_WORDS(MEM_WORDS)) u_data_memory (
        .clk (clk),
        .bus (mem_bus.target)
    );

    clint u_clint (
        .clk        (clk),
        .rst_n      (sys_resetn),
        .mtime_tick (mtime_tick),
        .bus        (clint_bus.target),
        .msw_irq    (msw_irq),
        .mtimer_irq (mtimer_irq)
    );

    button_port u_button_port (
        .clk     (clk),
        .rst_n   (sys_resetn),
        .buttons (buttons),
        .bus     (btn_bus.target)
    );

    // one count per clock
    tick_counter #(.DIVISION(1)) u_cycle_counter (
        .clk   (clk),
        .rst_n (sys_resetn),
        .count (cycle_count),
        .tick  ()
    );

    // prescaled count, its tick also paces mtime
    tick_counter #(.DIVISION(MTIME_DIVISION)) u_mtime_counter (
        .clk   (clk),
        .rst_n (sys_resetn),
        .count (tick_count),
        .tick  (mtime_tick)
    );

    // counter read register, counters are read only
    always_ff @(posedge clk) begin
        if (cnt_bus.sel_ren) begin
            case (cnt_bus.offset)
                {20'h0, CNT_CYCLE_OFF}: cnt_bus.rdata.word <= cycle_count;
                {20'h0, CNT_TICK_OFF}:  cnt_bus.rdata.word <= tick_count;
                default:                cnt_bus.rdata.word <= '0;
            endcase
        end
    end

endmodule

/* tb/soc_ref_model.svh */
`ifndef SOC_REF_MODEL_SVH
`define SOC_REF_MODEL_SVH

// expected memory image, one entry per word index
bus_word_u   model_mem [MEM_WORDS];
logic        model_msip = 1'b0;
logic [63:0] model_cmp = '0;

// region from the top address byte
function automatic region_e region_of(input logic [31:0] addr);
    case (addr[31:24])
        8'h02:   return REG_CLINT;
        8'h10:   return REG_MEM;
        8'h20:   return REG_BTN;
        8'h30:   return REG_CNT;
        default: return REG_NONE;
    endcase
endfunction

// byte address of a memory word
function automatic logic [31:0] mem_addr(input int idx);
    return 32'h1000_0000 | (32'(idx) << 2);
endfunction

// expand byte_select into a bit mask
function automatic logic [31:0] lane_mask(input logic [3:0] be);
    return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
endfunction

function automatic void model_mem_write(input int idx, input logic [31:0] data,
                                        input logic [3:0] be);
    model_mem[idx].word = (model_mem[idx].word & ~lane_mask(be)) | (data & lane_mask(be));
endfunction

// msip and the two compare halves, mtime is not kept here
function automatic void model_clint_write(input logic [15:0] off, input logic [31:0] data,
                                          input logic [3:0] be);
    if (off == 16'h0000 && be[0])
        model_msip = data[0];
    if (off == 16'h4000)
        model_cmp[31:0] = (model_cmp[31:0] & ~lane_mask(be)) | (data & lane_mask(be));
    if (off == 16'h4004)
        model_cmp[63:32] = (model_cmp[63:32] & ~lane_mask(be)) | (data & lane_mask(be));
endfunction

function automatic bus_word_u model_clint_read(input logic [15:0] off);
    case (off)
        16'h0000: return {31'd0, model_msip};
        16'h4000: return model_cmp[31:0];
        16'h4004: return model_cmp[63:32];
        default:  return '0;
    endcase
endfunction

`endif

/* tb/soc_tb.sv */
`timescale 1ns/1ps

module soc_tb
    import soc_data_pkg::*;
    import soc_map_pkg::*;
();

    localparam int CLK_PERIOD        = 40;
    localparam int MEM_WORDS         = 256;
    localparam int MTIME_DIVISION    = 50;
    localparam int RESET_CYCLES_LOG2 = 4;
    localparam int RAND_OPS          = 300;
    localparam int OOR_OPS           = 24;
    localparam int BTN_OPS           = 16;
    localparam int MISC_OPS          = 16;
    localparam int MAX_K             = 20;
    localparam int MAX_N             = 6;
    // edges after the ext_reset release until sys_resetn is high
    localparam int RELEASE_EDGE      = (1 << RESET_CYCLES_LOG2) - 1;
    // run length in cycles for the watchdog
    localparam int NUM_ACCESSES = MEM_WORDS + RAND_OPS + OOR_OPS + BTN_OPS + MISC_OPS;
    localparam int WAIT_CYCLES  = 2 + (1 << RESET_CYCLES_LOG2) + 8 + MAX_K + 3 * BTN_OPS
                                  + (MAX_N + 2) * MTIME_DIVISION;
    localparam int WATCHDOG_CYCLES = NUM_ACCESSES * 4 + WAIT_CYCLES;

    logic        clk = 1'b0;
    logic        ext_reset;
    logic [31:0] bus_addr;
    logic [31:0] bus_wdata;
    logic [3:0]  bus_byte_select;
    logic        bus_ren;
    logic        bus_wen;
    logic [31:0] bus_rdata;
    logic        bus_ready;
    logic        bus_error;
    logic [7:0]  buttons;
    logic        msw_irq;
    logic        mtimer_irq;
    logic        sys_resetn;

    integer seed;
    int     error_count = 0;
    // running posedge count and what the last ready cycle saw
    int     cycle_num = 0;
    int     sample_cycle;
    logic   msw_at_ready;

    `include "soc_ref_model.svh"

    soc_periph_top #(
        .MEM_WORDS         (MEM_WORDS),
        .MTIME_DIVISION    (MTIME_DIVISION),
        .RESET_CYCLES_LOG2 (RESET_CYCLES_LOG2)
    ) DUT (
        .clk (clk), .ext_reset (ext_reset),
        .bus_addr (bus_addr), .bus_wdata (bus_wdata), .bus_byte_select (bus_byte_select),
        .bus_ren (bus_ren), .bus_wen (bus_wen), .bus_rdata (bus_rdata),
        .bus_ready (bus_ready), .bus_error (bus_error), .buttons (buttons),
        .msw_irq (msw_irq), .mtimer_irq (mtimer_irq), .sys_resetn (sys_resetn)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) cycle_num <= cycle_num + 1;

    task automatic stop_on_error();
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_word(input string name, input bus_word_u got, input bus_word_u exp);
        if (got !== exp) begin
            error_count++;
            $display("FAIL time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            error_count++;
            $display("FAIL time=%0t signal=%s got=%b expected=%b", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("FAIL time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    // one strobe cycle with a single ready pulse right after it
    task automatic bus_access(input logic wr, input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] be, output bus_word_u rd, output logic err);
        @(posedge clk);
        bus_addr        <= addr;
        bus_wdata       <= data;
        bus_byte_select <= be;
        bus_ren         <= !wr;
        bus_wen         <= wr;
        @(negedge clk);
        check_bit("bus_ready", bus_ready, 1'b0);
        @(posedge clk);
        bus_ren <= 1'b0;
        bus_wen <= 1'b0;
        @(negedge clk);
        check_bit("bus_ready", bus_ready, 1'b1);
        sample_cycle = cycle_num;
        msw_at_ready = msw_irq;
        rd           = bus_rdata;
        err          = bus_error;
        @(negedge clk);
        check_bit("bus_ready", bus_ready, 1'b0);
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        stop_on_error();
    end

    initial begin : main
        bus_word_u   rd;
        bus_word_u   c1;
        logic        err;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] op;
        logic [63:0] mt;
        int          idx;
        int          k;
        int          n;
        int          s1;
        int          limit;

        seed            = 32'h3faa_a23d;
        ext_reset       = 1'b1;
        bus_addr        = '0;
        bus_wdata       = '0;
        bus_byte_select = '0;
        bus_ren         = 1'b0;
        bus_wen         = 1'b0;
        buttons         = '0;

        // reset held for two cycles
        @(posedge clk);
        ext_reset <= 1'b0;
        repeat (2) @(posedge clk);
        ext_reset <= 1'b1;
        // sys_resetn rises on its edge, outputs stay quiet through a few idle cycles
        for (int i = 0; i < RELEASE_EDGE + 5; i++) begin
            @(negedge clk);
            check_bit("sys_resetn", sys_resetn, i >= RELEASE_EDGE);
            check_bit("bus_ready", bus_ready, 1'b0);
            check_bit("bus_error", bus_error, 1'b0);
            check_bit("msw_irq", msw_irq, 1'b0);
            check_bit("mtimer_irq", mtimer_irq, 1'b0);
        end

        // cycle counter read twice with k idle clocks between the accesses
        k = 1 + ($unsigned($random(seed)) % MAX_K);
        bus_access(1'b0, 32'h3000_0000, '0, 4'hf, c1, err);
        s1 = sample_cycle;
        repeat (k) @(posedge clk);
        bus_access(1'b0, 32'h3000_0000, '0, 4'hf, rd, err);
        check_word("cycle_count delta", rd.word - c1.word, 32'(sample_cycle - s1));

        // fill the whole memory so every later read has a known value
        for (int i = 0; i < MEM_WORDS; i++) begin
            data = (32'(i) * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
            bus_access(1'b1, mem_addr(i), data, 4'hf, rd, err);
            model_mem_write(i, data, 4'hf);
        end

        // random lane writes mixed with reads
        for (int i = 0; i < RAND_OPS; i++) begin
            idx  = $unsigned($random(seed)) % MEM_WORDS;
            data = $random(seed);
            op   = $random(seed);
            if (op[0]) begin
                bus_access(1'b1, mem_addr(idx), data, op[7:4], rd, err);
                model_mem_write(idx, data, op[7:4]);
            end else begin
                bus_access(1'b0, mem_addr(idx), '0, 4'hf, rd, err);
                check_word("bus_rdata", rd, model_mem[idx]);
            end
            check_bit("bus_error", err, 1'b0);
        end

        // unmapped reads give zero and an error
        for (int i = 0; i < OOR_OPS; i++) begin
            addr = $random(seed);
            if (region_of(addr) != REG_NONE)
                addr[24] = ~addr[24];
            bus_access(1'b0, addr, '0, 4'hf, rd, err);
            check_word("bus_rdata", rd, '0);
            check_bit("bus_error", err, region_of(addr) == REG_NONE);
        end

        // software interrupt set and cleared with a read back of each
        for (int v = 1; v >= 0; v--) begin
            bus_access(1'b1, 32'h0200_0000, 32'(v), 4'b0001, rd, err);
            model_clint_write(16'h0000, 32'(v), 4'b0001);
            check_bit("msw_irq", msw_at_ready, v[0]);
            bus_access(1'b0, 32'h0200_0000, '0, 4'hf, rd, err);
            check_word("msip", rd, model_clint_read(16'h0000));
        end

        // timer compare a few ticks ahead of mtime
        n = 2 + ($unsigned($random(seed)) % (MAX_N - 1));
        bus_access(1'b0, 32'h0200_bff8, '0, 4'hf, rd, err);
        mt[31:0] = rd.word;
        bus_access(1'b0, 32'h0200_bffc, '0, 4'hf, rd, err);
        mt[63:32] = rd.word;
        mt = mt + 64'(n);
        bus_access(1'b1, 32'h0200_4000, mt[31:0], 4'hf, rd, err);
        model_clint_write(16'h4000, mt[31:0], 4'hf);
        bus_access(1'b1, 32'h0200_4004, mt[63:32], 4'hf, rd, err);
        model_clint_write(16'h4004, mt[63:32], 4'hf);
        check_bit("mtimer_irq", mtimer_irq, 1'b0);
        bus_access(1'b0, 32'h0200_4000, '0, 4'hf, rd, err);
        check_word("mtimecmp_lo", rd, model_clint_read(16'h4000));
        limit = (n + 2) * MTIME_DIVISION;
        for (int i = 0; i < limit && mtimer_irq !== 1'b1; i++)
            @(negedge clk);
        if (mtimer_irq !== 1'b1) begin
            $display("timer interrupt did not rise within %0d cycles", limit);
            stop_on_error();
        end
        bus_access(1'b0, 32'h0200_bff8, '0, 4'hf, rd, err);
        mt[31:0] = rd.word;
        bus_access(1'b0, 32'h0200_bffc, '0, 4'hf, rd, err);
        mt[63:32] = rd.word;
        check_bit("mtime >= mtimecmp", mt >= model_cmp, 1'b1);
        // compare moved far ahead so the irq drops
        mt = model_cmp + 64'd1000;
        bus_access(1'b1, 32'h0200_4000, mt[31:0], 4'hf, rd, err);
        model_clint_write(16'h4000, mt[31:0], 4'hf);
        bus_access(1'b1, 32'h0200_4004, mt[63:32], 4'hf, rd, err);
        model_clint_write(16'h4004, mt[63:32], 4'hf);
        check_bit("mtimer_irq", mtimer_irq, 1'b0);

        // buttons settle through the synchronizer before the read
        for (int i = 0; i < BTN_OPS; i++) begin
            data = $random(seed);
            @(posedge clk);
            buttons <= data[7:0];
            repeat (2) @(posedge clk);
            bus_access(1'b0, 32'h2000_0000, '0, 4'hf, rd, err);
            check_byte("bus_rdata[7:0]", rd.bytes[0], data[7:0]);
            for (int l = 1; l < LANES; l++)
                check_byte("bus_rdata upper lane", rd.bytes[l], 8'h00);
            check_bit("bus_error", err, 1'b0);
        end

        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* build.f */
+incdir+tb
hdl/soc_data_pkg.sv
hdl/soc_map_pkg.sv
hdl/cpu_bus_if.sv
hdl/reset_sync.sv
hdl/bus_decoder.sv
hdl/data_memory.sv
hdl/clint.sv
hdl/button_port.sv
hdl/tick_counter.sv
hdl/soc_periph_top.sv
tb/soc_tb.sv
